// ==== src/flow_pkg.sv ====
package flow_pkg;

  // host bus
  localparam int io_data_width = 32;
  localparam int io_strb_width = io_data_width / 8;
  localparam int io_addr_width = 22;

  // hash table memory
  localparam int data_width     = 128;
  localparam int acc_addr_width = 12;
  localparam int hash_blocks    = 4;
  localparam int hash_sel_bits  = $clog2(hash_blocks);

  // burst buffer holds one line from each bank
  localparam int burst_words = 2 * data_width / io_data_width;

  // memory read plus its output register
  localparam int rd_latency = 2;

  // register map, byte offsets
  localparam logic [6:0] reg_flow_req  = 7'h60;
  localparam logic [6:0] reg_flow_mode = 7'h64;
  localparam logic [6:0] win_burst     = 7'h40;

  // request word, decoded by the mode register
  typedef union packed {
    struct packed {
      logic [io_data_width-hash_sel_bits-acc_addr_width-2:0] unused;
      logic [hash_sel_bits-1:0]                              block;
      logic [acc_addr_width-1:0]                             line_addr;
      logic                                                  bank;
    } b16;
    struct packed {
      logic [io_data_width-hash_sel_bits-acc_addr_width-1:0] unused;
      logic [hash_sel_bits-1:0]                              block;
      logic [acc_addr_width-1:0]                             line_addr;
    } b32;
  } flow_req_word_t;

endpackage

// ==== src/mmio_regs.sv ====
`timescale 1ns/10ps

module mmio_regs (
  input  logic                                                   clk,
  input  logic                                                   rst,

  // host register bus
  input  logic                                                   io_en,
  input  logic                                                   io_wen,
  input  logic [flow_pkg::io_strb_width-1:0]                     io_strb,
  input  logic [flow_pkg::io_addr_width-1:0]                     io_addr,
  input  logic [flow_pkg::io_data_width-1:0]                     io_wr_data,
  output logic [flow_pkg::io_data_width-1:0]                     io_rd_data,
  output logic                                                   io_rd_valid,

  // read pipeline status and buffer
  input  logic                                                   flow_rd_ready,
  input  logic [flow_pkg::burst_words*flow_pkg::io_data_width-1:0] burst_data,

  // request to the read pipeline
  output logic                                                   req,
  output logic [flow_pkg::acc_addr_width-1:0]                    req_addr,
  output logic [flow_pkg::hash_sel_bits-1:0]                     req_block,
  output logic                                                   req_bank
);

  // word offset within the 128-byte register space
  logic [4:0] reg_idx;

  logic wr_access;
  logic rd_access;
  logic in_window;
  logic hit_req;
  logic hit_mode;

  // 0 selects the 16-byte decode
  logic mode_32b;
  logic stall;

  // buffer is valid only when no new request is on its way
  logic window_ok;

  logic [$clog2(flow_pkg::burst_words)-1:0] word_sel;
  logic [flow_pkg::io_data_width-1:0]       window_word;
  logic [flow_pkg::io_data_width-1:0]       mode_word;

  flow_pkg::flow_req_word_t req_word;

  assign reg_idx   = io_addr[6:2];
  assign wr_access = io_en && io_wen;
  assign rd_access = io_en && !io_wen;

  assign in_window = io_addr[6:5] == flow_pkg::win_burst[6:5];
  assign hit_req   = reg_idx == flow_pkg::reg_flow_req[6:2];
  assign hit_mode  = reg_idx == flow_pkg::reg_flow_mode[6:2];

  assign window_ok = flow_rd_ready && !req;

  // word pick inside the burst window
  assign word_sel    = io_addr[4:2];
  assign window_word = burst_data[word_sel*flow_pkg::io_data_width +: flow_pkg::io_data_width];

  assign mode_word = {{(flow_pkg::io_data_width-1){1'b0}}, mode_32b};

  assign req_word = io_wr_data;

  // control: request pulse, mode, read valid and stall
  always_ff @(posedge clk) begin
    if (rst) begin
      req         <= 1'b0;
      io_rd_valid <= 1'b0;
      stall       <= 1'b0;
      mode_32b    <= 1'b0;
    end else begin
      req         <= wr_access && hit_req;
      io_rd_valid <= 1'b0;

      // only byte 0 carries the mode bit
      if (wr_access && hit_mode && io_strb[0]) begin
        mode_32b <= io_wr_data[0];
      end

      if (stall) begin
        // retry until the buffer holds the latest request
        io_rd_valid <= window_ok;
        stall       <= !window_ok;
      end else if (rd_access) begin
        if (in_window) begin
          io_rd_valid <= window_ok;
          stall       <= !window_ok;
        end else begin
          io_rd_valid <= 1'b1;
        end
      end
    end
  end

  // request fields, held until the next request write
  always_ff @(posedge clk) begin
    if (wr_access && hit_req) begin
      if (mode_32b) begin
        // fixed bank order in 32-byte mode
        req_addr  <= req_word.b32.line_addr;
        req_block <= req_word.b32.block;
        req_bank  <= 1'b0;
      end else begin
        req_addr  <= req_word.b16.line_addr;
        req_block <= req_word.b16.block;
        req_bank  <= req_word.b16.bank;
      end
    end
  end

  // read data, unmapped offsets give zero
  always_ff @(posedge clk) begin
    if (rd_access || stall) begin
      if (in_window) begin
        io_rd_data <= window_word;
      end else if (hit_mode) begin
        io_rd_data <= mode_word;
      end else begin
        io_rd_data <= '0;
      end
    end
  end

  // host must hold the address of a stalled read
  a_addr_hold: assert property (
    @(posedge clk) disable iff (rst)
    stall |-> $stable(io_addr)
  );

  // a stalled read answers only after the stall clears
  a_no_valid_in_stall: assert property (
    @(posedge clk) disable iff (rst)
    stall |-> !io_rd_valid
  );

endmodule

// ==== src/flow_rd_pipe.sv ====
`timescale 1ns/10ps

module flow_rd_pipe (
  input  logic                                                   clk,
  input  logic                                                   rst,

  // request from the register front end
  input  logic                                                   req,
  input  logic [flow_pkg::acc_addr_width-1:0]                    req_addr,
  input  logic [flow_pkg::hash_sel_bits-1:0]                     req_block,
  input  logic                                                   req_bank,

  // hash memory, same enable and address for every block
  output logic                                                   mem_en,
  output logic [flow_pkg::acc_addr_width-1:0]                    mem_addr,
  input  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0]  mem_rd_data_b1,
  input  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0]  mem_rd_data_b2,

  // burst buffer toward the host
  output logic                                                   flow_rd_ready,
  output logic [flow_pkg::burst_words*flow_pkg::io_data_width-1:0] burst_data
);

  // stage 0 is the memory request, the last stage meets the data
  logic [flow_pkg::rd_latency:0]                              valid_pipe;
  logic [flow_pkg::rd_latency:0][flow_pkg::hash_sel_bits-1:0] block_pipe;
  logic [flow_pkg::rd_latency:0]                              bank_pipe;

  logic                           load;
  logic [flow_pkg::data_width-1:0] line_b1;
  logic [flow_pkg::data_width-1:0] line_b2;

  assign load   = valid_pipe[flow_pkg::rd_latency];
  assign mem_en = valid_pipe[0];

  // named block out of each bank
  assign line_b1 = mem_rd_data_b1[block_pipe[flow_pkg::rd_latency]*flow_pkg::data_width +:
                                  flow_pkg::data_width];
  assign line_b2 = mem_rd_data_b2[block_pipe[flow_pkg::rd_latency]*flow_pkg::data_width +:
                                  flow_pkg::data_width];

  // valid chain and ready level
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_pipe    <= '0;
      flow_rd_ready <= 1'b0;
    end else begin
      valid_pipe <= {valid_pipe[flow_pkg::rd_latency-1:0], req};

      // held from the load until the next request
      flow_rd_ready <= load || (flow_rd_ready && !req);
    end
  end

  // address once, block and bank follow the valid
  always_ff @(posedge clk) begin
    mem_addr   <= req_addr;
    block_pipe <= {block_pipe[flow_pkg::rd_latency-1:0], req_block};
    bank_pipe  <= {bank_pipe[flow_pkg::rd_latency-1:0], req_bank};

    // bank bit decides which line sits in the low half
    if (load) begin
      if (bank_pipe[flow_pkg::rd_latency]) begin
        burst_data <= {line_b1, line_b2};
      end else begin
        burst_data <= {line_b2, line_b1};
      end
    end
  end

  // memory is enabled one cycle after the front end pulse
  a_en_follows_req: assert property (
    @(posedge clk) disable iff (rst)
    mem_en == $past(req)
  );

  // a new request hides the old buffer at once
  a_ready_drops: assert property (
    @(posedge clk) disable iff (rst)
    req && !load |=> !flow_rd_ready
  );

endmodule

// ==== src/hash_rd_top.sv ====
`timescale 1ns/10ps

module hash_rd_top (
  input  logic                                                   clk,
  input  logic                                                   rst,

  // host register bus
  input  logic                                                   io_en,
  input  logic                                                   io_wen,
  input  logic [flow_pkg::io_strb_width-1:0]                     io_strb,
  input  logic [flow_pkg::io_addr_width-1:0]                     io_addr,
  input  logic [flow_pkg::io_data_width-1:0]                     io_wr_data,
  output logic [flow_pkg::io_data_width-1:0]                     io_rd_data,
  output logic                                                   io_rd_valid,

  // hash table memory, both banks
  output logic                                                   mem_en,
  output logic [flow_pkg::acc_addr_width-1:0]                    mem_addr,
  input  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0]  mem_rd_data_b1,
  input  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0]  mem_rd_data_b2
);

  // front end to pipeline
  logic                                  req;
  logic [flow_pkg::acc_addr_width-1:0]   req_addr;
  logic [flow_pkg::hash_sel_bits-1:0]    req_block;
  logic                                  req_bank;

  // pipeline to front end
  logic                                                   flow_rd_ready;
  logic [flow_pkg::burst_words*flow_pkg::io_data_width-1:0] burst_data;

  mmio_regs u_mmio_regs (
    .clk           (clk),
    .rst           (rst),
    .io_en         (io_en),
    .io_wen        (io_wen),
    .io_strb       (io_strb),
    .io_addr       (io_addr),
    .io_wr_data    (io_wr_data),
    .io_rd_data    (io_rd_data),
    .io_rd_valid   (io_rd_valid),
    .flow_rd_ready (flow_rd_ready),
    .burst_data    (burst_data),
    .req           (req),
    .req_addr      (req_addr),
    .req_block     (req_block),
    .req_bank      (req_bank)
  );

  flow_rd_pipe u_flow_rd_pipe (
    .clk            (clk),
    .rst            (rst),
    .req            (req),
    .req_addr       (req_addr),
    .req_block      (req_block),
    .req_bank       (req_bank),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .mem_rd_data_b1 (mem_rd_data_b1),
    .mem_rd_data_b2 (mem_rd_data_b2),
    .flow_rd_ready  (flow_rd_ready),
    .burst_data     (burst_data)
  );

endmodule

// ==== testbench/tb_hash_rd.sv ====
`timescale 1ns/10ps

module tb_hash_rd;

  localparam int wait_limit  = 50;
  localparam int cycle_limit = 20000;

  logic                                                  clk;
  logic                                                  rst;
  logic                                                  io_en;
  logic                                                  io_wen;
  logic [flow_pkg::io_strb_width-1:0]                    io_strb;
  logic [flow_pkg::io_addr_width-1:0]                    io_addr;
  logic [flow_pkg::io_data_width-1:0]                    io_wr_data;
  logic [flow_pkg::io_data_width-1:0]                    io_rd_data;
  logic                                                  io_rd_valid;
  logic                                                  mem_en;
  logic [flow_pkg::acc_addr_width-1:0]                   mem_addr;
  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0] mem_rd_data_b1;
  logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0] mem_rd_data_b2;

  // hash memory model with an address register and an output register
  logic                                en_q1;
  logic [flow_pkg::acc_addr_width-1:0] addr_q1;

  logic [15:0] lfsr_state;
  int          total_checks;
  int          total_errors;
  int          test_checks;
  int          test_errors;

  hash_rd_top UUT (
    .clk            (clk),
    .rst            (rst),
    .io_en          (io_en),
    .io_wen         (io_wen),
    .io_strb        (io_strb),
    .io_addr        (io_addr),
    .io_wr_data     (io_wr_data),
    .io_rd_data     (io_rd_data),
    .io_rd_valid    (io_rd_valid),
    .mem_en         (mem_en),
    .mem_addr       (mem_addr),
    .mem_rd_data_b1 (mem_rd_data_b1),
    .mem_rd_data_b2 (mem_rd_data_b2)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // word k of a line is {bank id, block, line address, k} under 0xA5
  function automatic logic [31:0] model_word(input logic [1:0] bank_id, input logic [1:0] block,
                                             input logic [11:0] addr, input logic [1:0] k);
    model_word = {8'hA5, 6'd0, bank_id, block, addr, k};
  endfunction

  function automatic logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0] model_bank(
      input logic [1:0] bank_id, input logic [11:0] addr);
    logic [flow_pkg::hash_blocks*flow_pkg::data_width-1:0] lines;
    for (int b = 0; b < flow_pkg::hash_blocks; b++) begin
      for (int k = 0; k < 4; k++) begin
        lines[b*flow_pkg::data_width + k*32 +: 32] = model_word(bank_id, 2'(b), addr, 2'(k));
      end
    end
    model_bank = lines;
  endfunction

  // ids 1 and 2 stand for b1 and b2, and bank 0 puts b1 in words 0 to 3
  function automatic logic [31:0] window_word(input int idx, input logic [11:0] addr,
                                              input logic [1:0] block, input logic bank);
    logic [1:0] low_id;
    logic [1:0] high_id;
    low_id  = bank ? 2'd2 : 2'd1;
    high_id = bank ? 2'd1 : 2'd2;
    window_word = model_word((idx < 4) ? low_id : high_id, block, addr, 2'(idx % 4));
  endfunction

  always_ff @(posedge clk) begin
    if (rst) begin
      en_q1          <= 1'b0;
      mem_rd_data_b1 <= '0;
      mem_rd_data_b2 <= '0;
    end else begin
      en_q1 <= mem_en;
      if (mem_en) begin
        addr_q1 <= mem_addr;
      end
      if (en_q1) begin
        mem_rd_data_b1 <= model_bank(2'd1, addr_q1);
        mem_rd_data_b2 <= model_bank(2'd2, addr_q1);
      end
    end
  end

  // Galois form with taps 16, 14, 13 and 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    lfsr_next = n;
  endfunction

  task automatic take_bits(input int n, output logic [15:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val        = {val[14:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $finish;
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    test_checks++;
    assert (got === exp) else begin
      test_errors++;
      $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_latency(input string what, input int got, input int exp);
    test_checks++;
    assert (got == exp) else begin
      test_errors++;
      $display("%s answered %0d cycles after io_en instead of %0d", what, got, exp);
    end
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
    test_checks = 0;
    test_errors = 0;
  endtask

  // starts on a falling edge and returns on the next one with the bus idle
  task automatic bus_write(input logic [6:0] offset, input logic [31:0] data,
                           input logic [3:0] strb);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_strb    = strb;
    io_addr    = {15'd0, offset};
    io_wr_data = data;
    @(negedge clk);
    io_en   = 1'b0;
    io_wen  = 1'b0;
    io_strb = '0;
  endtask

  // address stays on the bus until the valid pulse
  task automatic bus_read(input logic [6:0] offset, output logic [31:0] data, output int cycles);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_strb = '0;
    io_addr = {15'd0, offset};
    @(negedge clk);
    io_en  = 1'b0;
    cycles = 1;
    while (!io_rd_valid && cycles < wait_limit) begin
      @(negedge clk);
      cycles++;
    end
    if (!io_rd_valid) begin
      test_errors++;
      $display("read of offset 0x%h never got io_rd_valid", offset);
    end
    data = io_rd_data;
  endtask

  task automatic wait_settled();
    int count;
    count = 0;
    while (!(UUT.flow_rd_ready && !UUT.req) && count < wait_limit) begin
      @(negedge clk);
      count++;
    end
    if (!(UUT.flow_rd_ready && !UUT.req)) begin
      test_errors++;
      $display("burst buffer never became ready after a request");
    end
  endtask

  task automatic read_window(input logic [11:0] addr, input logic [1:0] block, input logic bank);
    logic [31:0] data;
    int          cycles;
    for (int i = 0; i < flow_pkg::burst_words; i++) begin
      bus_read(flow_pkg::win_burst + 7'(4 * i), data, cycles);
      check_value($sformatf("io_rd_data word %0d", i), data, window_word(i, addr, block, bank));
      check_latency($sformatf("window word %0d", i), cycles, 1);
    end
  endtask

  a_valid_low_after_reset: assert property (@(posedge clk) rst |=> !io_rd_valid)
    else begin
      total_errors++;
      $display("Fail io_rd_valid after reset: got 0x1, expected 0x0");
    end

  initial begin
    repeat (cycle_limit) @(posedge clk);
    abort_run("simulation ran past its cycle limit");
  end

  initial begin
    flow_pkg::flow_req_word_t req_word;
    logic [15:0] rnd;
    logic [11:0] addr;
    logic [1:0]  block;
    logic [11:0] old_addr;
    logic [31:0] data;
    int          cycles;
    int          idx;

    rst          = 1'b1;
    io_en        = 1'b0;
    io_wen       = 1'b0;
    io_strb      = '0;
    io_addr      = '0;
    io_wr_data   = '0;
    lfsr_state   = 16'd98;
    total_checks = 0;
    total_errors = 0;
    test_checks  = 0;
    test_errors  = 0;

    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    // test 1 covers the reset state
    check_value("io_rd_valid", {31'd0, io_rd_valid}, 32'd0);
    bus_read(flow_pkg::reg_flow_mode, data, cycles);
    check_value("io_rd_data mode", data, 32'd0);
    check_latency("mode read", cycles, 1);
    end_test(1, "reset state");

    // test 2 covers the mode byte strobe
    bus_write(flow_pkg::reg_flow_mode, 32'd1, 4'b1110);
    bus_read(flow_pkg::reg_flow_mode, data, cycles);
    check_value("io_rd_data mode", data, 32'd0);
    bus_write(flow_pkg::reg_flow_mode, 32'd1, 4'b0001);
    bus_read(flow_pkg::reg_flow_mode, data, cycles);
    check_value("io_rd_data mode", data, 32'd1);
    end_test(2, "mode strobe");

    // test 3 in 16-byte mode with both bank orders
    bus_write(flow_pkg::reg_flow_mode, 32'd0, 4'b1111);
    for (int bank = 0; bank < 2; bank++) begin
      take_bits(12, rnd);
      addr = rnd[11:0];
      take_bits(2, rnd);
      block             = rnd[1:0];
      req_word          = '0;
      req_word.b16.bank = 1'(bank);
      req_word.b16.line_addr = addr;
      req_word.b16.block     = block;
      bus_write(flow_pkg::reg_flow_req, req_word, 4'b1111);
      wait_settled();
      read_window(addr, block, 1'(bank));
    end
    end_test(3, "16-byte burst");

    // test 4 in 32-byte mode with the fixed bank order
    bus_write(flow_pkg::reg_flow_mode, 32'd1, 4'b1111);
    take_bits(12, rnd);
    addr = rnd[11:0];
    take_bits(2, rnd);
    block                  = rnd[1:0];
    req_word               = '0;
    req_word.b32.line_addr = addr;
    req_word.b32.block     = block;
    bus_write(flow_pkg::reg_flow_req, req_word, 4'b1111);
    wait_settled();
    read_window(addr, block, 1'b0);
    end_test(4, "32-byte burst");

    // test 5 reads the window right behind a new request
    old_addr = addr;
    take_bits(12, rnd);
    addr = rnd[11:0];
    if (addr == old_addr) begin
      addr[0] = ~addr[0];
    end
    take_bits(2, rnd);
    block = rnd[1:0];
    take_bits(3, rnd);
    idx                    = int'(rnd[2:0]);
    req_word               = '0;
    req_word.b32.line_addr = addr;
    req_word.b32.block     = block;
    bus_write(flow_pkg::reg_flow_req, req_word, 4'b1111);
    bus_read(flow_pkg::win_burst + 7'(4 * idx), data, cycles);
    test_checks++;
    assert (cycles > 1) else begin
      test_errors++;
      $display("window read right after a request did not stall");
    end
    check_value("io_rd_data stalled word", data, window_word(idx, addr, block, 1'b0));
    end_test(5, "stalled read");

    // test 6 reads an unmapped offset
    bus_read(7'h68, data, cycles);
    check_value("io_rd_data unmapped", data, 32'd0);
    check_latency("unmapped read", cycles, 1);
    end_test(6, "unmapped read");

    $display("checks run %0d, errors %0d", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== vlog.f ====
src/flow_pkg.sv
src/mmio_regs.sv
src/flow_rd_pipe.sv
src/hash_rd_top.sv
testbench/tb_hash_rd.sv

// ==== Bender.yml ====
package:
  name: hash_rd

sources:
  - src/flow_pkg.sv
  - src/mmio_regs.sv
  - src/flow_rd_pipe.sv
  - src/hash_rd_top.sv
  - target: simulation
    files:
      - testbench/tb_hash_rd.sv
